//--- Bender.yml
package:
  name: icache

sources:
  # Packages first, then leaf modules, then the top level
  - common/icache_geom_pkg.sv
  - common/icache_ctrl_pkg.sv
  - icache_core/icache_flop_array.sv
  - icache_core/icache_line_store.sv
  - verilog/icache_addr_decode.sv
  - icache_core/icache_control.sv
  - icache_core/icache_way_select.sv
  - verilog/icache_top.sv

  # Testbench, top module icache_tb
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/icache_mem_model.sv
      - verification/icache_tb.sv

//--- common/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

    // Controller states
    // LOOKUP compares tags, FILL waits on memory, REFILL re-reads the arrays
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        REFILL
    } ctrl_state_t;

endpackage

//--- common/icache_geom_pkg.sv
package icache_geom_pkg;

    // Four ways, tied to the 3-bit tree PLRU
    localparam int WAYS = 4;

    // 32-byte lines of 32-bit words
    localparam int LINE_BITS      = 256;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_BITS    = 5;

    // One line, written whole from memory and read back by word offset
    // Word 0 sits in the least significant bits
    typedef union packed {
        logic [LINE_BITS-1:0]                 flat;
        logic [WORDS_PER_LINE-1:0][31:0]      words;
    } cache_line_t;

    // Tree PLRU bits, each pointing toward the next victim
    // Bit 0 is the root and picks pair 0-1 (0) or pair 2-3 (1)
    // Bit 1 picks way 0 or way 1, bit 2 picks way 2 or way 3
    typedef logic [2:0] plru_t;

endpackage

//--- compile.f
common/icache_geom_pkg.sv
common/icache_ctrl_pkg.sv
icache_core/icache_flop_array.sv
icache_core/icache_line_store.sv
verilog/icache_addr_decode.sv
icache_core/icache_control.sv
icache_core/icache_way_select.sv
verilog/icache_top.sv
verification/tb_clock.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

//--- icache_core/icache_control.sv
`timescale 1ns/1ps

module icache_control (
    input  logic clk,
    input  logic arst_n,
    input  logic ufp_rmask,
    input  logic hit,
    input  logic dfp_resp,
    output logic lookup_en,
    output logic fill_we,
    output logic resp_en,
    output logic dfp_read
);
    import icache_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    // High during the cycle the response is on the CPU port
    logic resp_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            resp_q <= 1'b0;
        end else begin
            state  <= state_next;
            resp_q <= resp_en;
        end
    end

    // The old request is still on the port while its response is out
    assign lookup_en = (state == IDLE) && ufp_rmask && !resp_q;

    assign resp_en  = (state == LOOKUP) && hit;
    assign fill_we  = (state == FILL) && dfp_resp;
    assign dfp_read = (state == FILL);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (lookup_en) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_next = IDLE;
                end else begin
                    state_next = FILL;
                end
            end
            FILL: begin
                // Hold the memory request until the line comes back
                if (dfp_resp) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                // Arrays now return the new line, so LOOKUP will hit
                state_next = LOOKUP;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

//--- icache_core/icache_flop_array.sv
`timescale 1ns/1ps

module icache_flop_array #(
    parameter int  NUM_SETS   = 16,
    parameter int  WIDTH      = 1,
    localparam int INDEX_BITS = $clog2(NUM_SETS)
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  we,
    input  logic [INDEX_BITS-1:0] addr,
    input  logic [WIDTH-1:0]      din,
    output logic [WIDTH-1:0]      dout
);

    logic [WIDTH-1:0] regs [NUM_SETS];

    // Read data lands one cycle after the address, like the line store
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                regs[s] <= '0;
            end
            dout <= '0;
        end else begin
            if (we) begin
                regs[addr] <= din;
            end
            dout <= regs[addr];
        end
    end

endmodule

//--- icache_core/icache_line_store.sv
`timescale 1ns/1ps

module icache_line_store #(
    parameter int  NUM_SETS   = 16,
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS   = 32 - icache_geom_pkg::OFFSET_BITS - INDEX_BITS
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [INDEX_BITS-1:0]        addr,
    input  logic [TAG_BITS-1:0]          tag_in,
    input  icache_geom_pkg::cache_line_t line_in,
    output logic [TAG_BITS-1:0]          tag_out,
    output icache_geom_pkg::cache_line_t line_out
);
    import icache_geom_pkg::*;

    logic [TAG_BITS-1:0] tag_mem [NUM_SETS];
    cache_line_t         line_mem [NUM_SETS];

    // A read on the write edge returns the old contents
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[addr]  <= tag_in;
            line_mem[addr] <= line_in;
        end
        tag_out  <= tag_mem[addr];
        line_out <= line_mem[addr];
    end

endmodule

//--- icache_core/icache_way_select.sv
`timescale 1ns/1ps

module icache_way_select #(
    parameter int  NUM_SETS   = 16,
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS   = 32 - icache_geom_pkg::OFFSET_BITS - INDEX_BITS,
    localparam int WORD_BITS  = $clog2(icache_geom_pkg::WORDS_PER_LINE)
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [TAG_BITS-1:0]                  req_tag,
    input  logic [WORD_BITS-1:0]                 req_word,
    input  logic [icache_geom_pkg::WAYS-1:0]     ways_valid,
    input  logic [TAG_BITS-1:0]                  ways_tag [icache_geom_pkg::WAYS],
    input  icache_geom_pkg::cache_line_t         ways_line [icache_geom_pkg::WAYS],
    input  icache_geom_pkg::plru_t               plru_bits,
    input  logic                                 fill_we,
    input  logic                                 resp_en,
    input  logic [icache_geom_pkg::LINE_BITS-1:0] dfp_rdata,
    output logic                                 hit,
    output icache_geom_pkg::plru_t               set_plru_bits,
    output logic                                 plru_we,
    output logic [icache_geom_pkg::WAYS-1:0]     way_we,
    output icache_geom_pkg::cache_line_t         fill_line,
    output logic [31:0]                          ufp_rdata,
    output logic                                 ufp_resp
);
    import icache_geom_pkg::*;

    localparam int WAY_BITS = $clog2(WAYS);

    logic [WAYS-1:0]     match;
    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] victim_way;
    cache_line_t         hit_line;

    always_comb begin
        match   = '0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            match[w] = ways_valid[w] && (ways_tag[w] == req_tag);
            if (match[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit      = |match;
    assign hit_line = ways_line[hit_way];

    // Lowest invalid way first, else follow the tree
    always_comb begin
        if (plru_bits[0]) begin
            victim_way = {1'b1, plru_bits[2]};
        end else begin
            victim_way = {1'b0, plru_bits[1]};
        end
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!ways_valid[w]) begin
                victim_way = WAY_BITS'(w);
            end
        end
    end

    // Point the tree away from the way just used
    always_comb begin
        set_plru_bits    = plru_bits;
        set_plru_bits[0] = ~hit_way[1];
        if (hit_way[1]) begin
            set_plru_bits[2] = ~hit_way[0];
        end else begin
            set_plru_bits[1] = ~hit_way[0];
        end
    end

    assign plru_we = resp_en;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_we[w] = fill_we && (victim_way == WAY_BITS'(w));
        end
    end

    assign fill_line.flat = dfp_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ufp_resp <= 1'b0;
        end else begin
            ufp_resp <= resp_en;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_en) begin
            ufp_rdata <= hit_line.words[req_word];
        end
    end

endmodule

//--- verification/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model #(
    parameter int LATENCY = 3
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic [31:0]  dfp_addr,
    input  logic         dfp_read,
    output logic [255:0] dfp_rdata,
    output logic         dfp_resp,
    output int           read_count,
    output logic [31:0]  last_read_addr
);

    logic read_q;
    int   wait_cnt;

    // Word k of line A holds A + 4k xor 32'h5a5a0000, word 0 at the bottom
    function automatic logic [255:0] line_data(input logic [31:0] line_addr);
        logic [255:0] line;
        for (int k = 0; k < 8; k++) begin
            line[k*32 +: 32] = (line_addr + 32'(4 * k)) ^ 32'h5a5a0000;
        end
        return line;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dfp_resp       <= 1'b0;
            dfp_rdata      <= '0;
            read_q         <= 1'b0;
            wait_cnt       <= 0;
            read_count     <= 0;
            last_read_addr <= '0;
        end else begin
            read_q <= dfp_read;
            // Count each new request once
            if (dfp_read && !read_q) begin
                read_count     <= read_count + 1;
                last_read_addr <= dfp_addr;
            end
            // The cache still shows dfp_read on the response edge
            if (dfp_resp) begin
                dfp_resp <= 1'b0;
                wait_cnt <= 0;
            end else if (dfp_read) begin
                if (wait_cnt == LATENCY - 1) begin
                    dfp_resp  <= 1'b1;
                    dfp_rdata <= line_data(dfp_addr);
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule

//--- verification/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int NUM_SETS   = 16;
    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = 32 - 5 - INDEX_BITS;
    localparam int RESP_LIMIT = 64;
    // About 230 reads at no more than 10 cycles each, plus resets
    localparam int CYCLE_LIMIT = 4000;
    localparam logic [31:0] SEED = 32'hf67ae07b;

    logic         clk;
    logic         arst_n;
    logic [31:0]  ufp_addr;
    logic         ufp_rmask;
    logic [31:0]  ufp_rdata;
    logic         ufp_resp;
    logic [31:0]  dfp_addr;
    logic         dfp_read;
    logic [255:0] dfp_rdata;
    logic         dfp_resp;
    int           read_count;
    logic [31:0]  last_read_addr;

    int cycle_count;
    int check_count;
    int error_count;

    // Expected cache contents, kept from the replacement rules
    logic                shadow_valid [NUM_SETS][4];
    logic [TAG_BITS-1:0] shadow_tag   [NUM_SETS][4];
    logic [2:0]          shadow_plru  [NUM_SETS];

    tb_clock #(.PERIOD_NS(100.0)) i_clock (.clk(clk));

    icache_top #(.NUM_SETS(NUM_SETS)) i_icache_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    icache_mem_model #(.LATENCY(3)) i_mem_model (
        .clk            (clk),
        .arst_n         (arst_n),
        .dfp_addr       (dfp_addr),
        .dfp_read       (dfp_read),
        .dfp_rdata      (dfp_rdata),
        .dfp_resp       (dfp_resp),
        .read_count     (read_count),
        .last_read_addr (last_read_addr)
    );

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic int set_of(input logic [31:0] addr);
        return int'(addr[5 +: INDEX_BITS]);
    endfunction

    function automatic int find_way(input logic [31:0] addr);
        for (int w = 0; w < 4; w++) begin
            if (shadow_valid[set_of(addr)][w] &&
                shadow_tag[set_of(addr)][w] == addr[31 -: TAG_BITS]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Lowest empty way, else walk the tree
    function automatic int pick_victim(input int set);
        for (int w = 0; w < 4; w++) begin
            if (!shadow_valid[set][w]) begin
                return w;
            end
        end
        if (!shadow_plru[set][0]) begin
            return shadow_plru[set][1] ? 1 : 0;
        end
        return shadow_plru[set][2] ? 3 : 2;
    endfunction

    function automatic void touch_way(input int set, input int way);
        shadow_plru[set][0] = (way < 2);
        if (way < 2) begin
            shadow_plru[set][1] = (way == 0);
        end else begin
            shadow_plru[set][2] = (way == 2);
        end
    endfunction

    function automatic void clear_shadow();
        for (int s = 0; s < NUM_SETS; s++) begin
            shadow_plru[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                shadow_valid[s][w] = 1'b0;
                shadow_tag[s][w]   = '0;
            end
        end
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic pulse_reset(input int cycles);
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (cycles) @(posedge clk);
        arst_n <= 1'b1;
        clear_shadow();
    endtask

    // One request, held until the response pulse
    task automatic fetch(input logic [31:0] addr, output logic [31:0] data,
                         output int cycles, output bit got_resp);
        cycles   = 0;
        got_resp = 1'b0;
        data     = '0;
        @(posedge clk);
        ufp_addr  <= addr;
        ufp_rmask <= 1'b1;
        while (!got_resp && cycles < RESP_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (ufp_resp) begin
                got_resp = 1'b1;
                data     = ufp_rdata;
            end
        end
        @(posedge clk);
        ufp_rmask <= 1'b0;
    endtask

    task automatic checked_read(input logic [31:0] addr, output bit was_miss);
        logic [31:0] data;
        int          cycles;
        bit          got_resp;
        int          reads_before;
        int          way;
        bit          expect_miss;
        way          = find_way(addr);
        expect_miss  = (way < 0);
        reads_before = read_count;
        fetch(addr, data, cycles, got_resp);
        // A miss shows up as a new memory read
        was_miss = (read_count != reads_before);
        if (!got_resp) begin
            error_count++;
            $display("ERROR at %0t: no response for address %h within %0d cycles",
                     $time, addr, RESP_LIMIT);
        end else begin
            check(data, expected_word(addr), $sformatf("data at %h", addr));
            if (expect_miss) begin
                check(read_count - reads_before, 1, $sformatf("memory reads for miss %h", addr));
                check(last_read_addr, addr & 32'hffff_ffe0, "fill address");
            end else begin
                check(read_count - reads_before, 0, $sformatf("memory reads for hit %h", addr));
                check(cycles, 2, $sformatf("hit latency at %h", addr));
            end
        end
        if (expect_miss) begin
            way = pick_victim(set_of(addr));
            shadow_valid[set_of(addr)][way] = 1'b1;
            shadow_tag[set_of(addr)][way]   = addr[31 -: TAG_BITS];
        end
        touch_way(set_of(addr), way);
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        $display("test %-12s done, %0d errors", name, error_count - errors_at_start);
    endtask

    task automatic cold_miss_test();
        int start;
        bit miss;
        start = error_count;
        checked_read(32'h0000_1044, miss);
        check(miss, 1'b1, "first read after reset misses");
        finish_test("cold_miss", start);
    endtask

    task automatic hit_timing_test();
        int start;
        bit miss;
        start = error_count;
        for (int k = 0; k < 8; k++) begin
            checked_read(32'h0000_1040 + 32'(4 * k), miss);
            check(miss, 1'b0, $sformatf("word %0d of filled line hits", k));
        end
        finish_test("hit_timing", start);
    endtask

    task automatic replacement_test();
        logic [31:0] line [1:5];
        int          start;
        bit          miss;
        start = error_count;
        for (int t = 1; t <= 5; t++) begin
            line[t] = (32'(t) << 9) | (32'd3 << 5);
        end
        // Ways 0 to 3 take lines 1 to 4 in turn
        for (int t = 1; t <= 4; t++) begin
            checked_read(line[t], miss);
            check(miss, 1'b1, $sformatf("fill of line %0d", t));
        end
        // Touch ways 2, 0, 3, 1, which leaves the tree on way 2
        checked_read(line[3], miss);
        checked_read(line[1], miss);
        checked_read(line[4], miss);
        checked_read(line[2], miss);
        checked_read(line[5], miss);
        check(miss, 1'b1, "fifth line misses");
        checked_read(line[1], miss);
        check(miss, 1'b0, "line 1 survives");
        checked_read(line[2], miss);
        check(miss, 1'b0, "line 2 survives");
        checked_read(line[4], miss);
        check(miss, 1'b0, "line 4 survives");
        checked_read(line[3], miss);
        check(miss, 1'b1, "evicted line 3 refetched");
        finish_test("replacement", start);
    endtask

    task automatic reset_invalidation_test();
        int start;
        bit miss;
        start = error_count;
        checked_read(32'h0000_1048, miss);
        check(miss, 1'b0, "cached line before reset");
        pulse_reset(2);
        checked_read(32'h0000_1048, miss);
        check(miss, 1'b1, "same line after reset");
        finish_test("reset_inval", start);
    endtask

    task automatic random_read_test();
        logic [31:0] addr;
        int          start;
        int          tag;
        int          set_idx;
        int          word;
        bit          miss;
        start = error_count;
        for (int i = 0; i < 200; i++) begin
            // Six tags over two sets forces evictions
            tag     = $urandom % 6;
            set_idx = $urandom % 2;
            word    = $urandom % 8;
            addr    = (32'(tag) << 9) | (32'(set_idx) << 5) | (32'(word) << 2);
            checked_read(addr, miss);
        end
        finish_test("random_reads", start);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run stopped after %0d cycles without finishing", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        arst_n      = 1'b0;
        ufp_addr    = '0;
        ufp_rmask   = 1'b0;
        check_count = 0;
        error_count = 0;
        void'($urandom(SEED));
        pulse_reset(16);

        cold_miss_test();
        hit_timing_test();
        replacement_test();
        reset_invalidation_test();
        random_read_test();

        $display("tests: 5, checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running, half a period per phase
    always begin
        #(PERIOD_NS / 2.0);
        clk = ~clk;
    end

endmodule

//--- verilog/icache_addr_decode.sv
`timescale 1ns/1ps

module icache_addr_decode #(
    parameter int  NUM_SETS   = 16,
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS   = 32 - icache_geom_pkg::OFFSET_BITS - INDEX_BITS
) (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    lookup_en,
    input  logic [31:0]                             ufp_addr,
    output logic [INDEX_BITS-1:0]                   req_index,
    output logic [TAG_BITS-1:0]                     req_tag,
    output logic [icache_geom_pkg::OFFSET_BITS-3:0] req_word,
    output logic [31:0]                             line_addr
);
    import icache_geom_pkg::*;

    logic [31:0] addr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_q <= '0;
        end else if (lookup_en) begin
            addr_q <= ufp_addr;
        end
    end

    // Live index while a request is taken, so the arrays read in step
    assign req_index = lookup_en ? ufp_addr[OFFSET_BITS +: INDEX_BITS]
                                 : addr_q[OFFSET_BITS +: INDEX_BITS];

    assign req_tag   = addr_q[31 -: TAG_BITS];
    assign req_word  = addr_q[OFFSET_BITS-1:2];
    assign line_addr = {addr_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int  NUM_SETS   = 16,
    localparam int INDEX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS   = 32 - icache_geom_pkg::OFFSET_BITS - INDEX_BITS
) (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // CPU side
    input  logic [31:0]                           ufp_addr,
    input  logic                                  ufp_rmask,
    output logic [31:0]                           ufp_rdata,
    output logic                                  ufp_resp,

    // Memory side
    output logic [31:0]                           dfp_addr,
    output logic                                  dfp_read,
    input  logic [icache_geom_pkg::LINE_BITS-1:0] dfp_rdata,
    input  logic                                  dfp_resp
);
    import icache_geom_pkg::*;

    logic                        lookup_en;
    logic                        hit;
    logic                        fill_we;
    logic                        resp_en;

    logic [INDEX_BITS-1:0]       req_index;
    logic [TAG_BITS-1:0]         req_tag;
    logic [OFFSET_BITS-3:0]      req_word;

    logic [WAYS-1:0]             ways_valid;
    logic [TAG_BITS-1:0]         ways_tag [WAYS];
    cache_line_t                 ways_line [WAYS];
    logic [WAYS-1:0]             way_we;
    cache_line_t                 fill_line;

    plru_t                       plru_bits;
    plru_t                       set_plru_bits;
    logic                        plru_we;

    icache_addr_decode #(.NUM_SETS(NUM_SETS)) i_addr_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .lookup_en (lookup_en),
        .ufp_addr  (ufp_addr),
        .req_index (req_index),
        .req_tag   (req_tag),
        .req_word  (req_word),
        .line_addr (dfp_addr)
    );

    icache_control i_control (
        .clk       (clk),
        .arst_n    (arst_n),
        .ufp_rmask (ufp_rmask),
        .hit       (hit),
        .dfp_resp  (dfp_resp),
        .lookup_en (lookup_en),
        .fill_we   (fill_we),
        .resp_en   (resp_en),
        .dfp_read  (dfp_read)
    );

    icache_way_select #(.NUM_SETS(NUM_SETS)) i_way_select (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_tag       (req_tag),
        .req_word      (req_word),
        .ways_valid    (ways_valid),
        .ways_tag      (ways_tag),
        .ways_line     (ways_line),
        .plru_bits     (plru_bits),
        .fill_we       (fill_we),
        .resp_en       (resp_en),
        .dfp_rdata     (dfp_rdata),
        .hit           (hit),
        .set_plru_bits (set_plru_bits),
        .plru_we       (plru_we),
        .way_we        (way_we),
        .fill_line     (fill_line),
        .ufp_rdata     (ufp_rdata),
        .ufp_resp      (ufp_resp)
    );

    icache_flop_array #(.NUM_SETS(NUM_SETS), .WIDTH($bits(plru_t))) i_plru_array (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (plru_we),
        .addr   (req_index),
        .din    (set_plru_bits),
        .dout   (plru_bits)
    );

    for (genvar i = 0; i < WAYS; i++) begin : g_way
        // A fill always leaves its way valid
        icache_flop_array #(.NUM_SETS(NUM_SETS), .WIDTH(1)) i_valid_array (
            .clk    (clk),
            .arst_n (arst_n),
            .we     (way_we[i]),
            .addr   (req_index),
            .din    (1'b1),
            .dout   (ways_valid[i])
        );

        icache_line_store #(.NUM_SETS(NUM_SETS)) i_line_store (
            .clk      (clk),
            .we       (way_we[i]),
            .addr     (req_index),
            .tag_in   (req_tag),
            .line_in  (fill_line),
            .tag_out  (ways_tag[i]),
            .line_out (ways_line[i])
        );
    end

endmodule
